// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - rtl/mem_pkg.sv
  - rtl/mem_timer.sv
  - rtl/mmio_cntr.sv
  - rtl/mem_bus_arbiter.sv
  - rtl/mem_model.sv
  - rtl/mem_subsys_top.sv
  - target: test
    files:
      - verification/mem_subsys_tb.sv

// ==== rtl/mem_bus_arbiter.sv ====
`timescale 1ns/1ps

module mem_bus_arbiter (
    input  logic           clk_in,
    input  logic           rst_n,
    input  logic           i_req_valid,
    output logic           i_req_ready,
    input  mem_pkg::word_t i_req_addr,
    output logic           i_resp_valid,
    output mem_pkg::word_t i_resp_rdata,
    input  logic           d_req_valid,
    output logic           d_req_ready,
    input  mem_pkg::word_t d_req_addr,
    input  logic           d_req_wen,
    input  mem_pkg::word_t d_req_wdata,
    output logic           d_resp_valid,
    output mem_pkg::word_t d_resp_rdata,
    output logic           mem_req_valid,
    input  logic           mem_req_ready,
    output mem_pkg::word_t mem_req_addr,
    output logic           mem_req_wen,
    output mem_pkg::word_t mem_req_wdata,
    input  logic           mem_resp_valid,
    input  mem_pkg::word_t mem_resp_rdata
);

    logic owner_valid;
    logic owner_is_d;
    logic idle;
    logic accept;

    assign idle = !owner_valid;

    // data side has fixed priority.
    assign mem_req_valid = idle && (d_req_valid || i_req_valid);
    assign mem_req_addr  = d_req_valid ? d_req_addr : i_req_addr;
    assign mem_req_wen   = d_req_valid && d_req_wen;       // fetch never writes.
    assign mem_req_wdata = d_req_valid ? d_req_wdata : '0;

    assign d_req_ready = idle && mem_req_ready;
    assign i_req_ready = idle && mem_req_ready && !d_req_valid;

    assign accept = mem_req_valid && mem_req_ready;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            owner_valid <= 1'b0;
            owner_is_d  <= 1'b0;
        end else if (accept) begin
            owner_valid <= 1'b1;
            owner_is_d  <= d_req_valid;
        end else if (mem_resp_valid) begin
            owner_valid <= 1'b0;   // response releases the bus.
        end
    end

    // response goes back to whoever holds the bus.
    assign d_resp_valid = mem_resp_valid && owner_valid && owner_is_d;
    assign i_resp_valid = mem_resp_valid && owner_valid && !owner_is_d;
    assign d_resp_rdata = mem_resp_rdata;
    assign i_resp_rdata = mem_resp_rdata;

    a_one_owner: assert property (@(posedge clk_in) disable iff (!rst_n)
        accept |=> (!mem_req_valid until mem_resp_valid));

    a_resp_owned: assert property (@(posedge clk_in) disable iff (!rst_n)
        mem_resp_valid |-> owner_valid);

endmodule

// ==== rtl/mem_model.sv ====
`timescale 1ns/1ps

module mem_model #(
    parameter int ADDR_WIDTH  = 10,
    parameter int DELAY_CYCLE = 4
) (
    input  logic           clk_in,
    input  logic           rst_n,
    input  logic           req_valid,
    output logic           req_ready,
    input  mem_pkg::word_t req_addr,
    input  logic           req_wen,
    input  mem_pkg::word_t req_wdata,
    output logic           resp_valid,
    output mem_pkg::word_t resp_rdata
);
    import mem_pkg::*;

    localparam int CNT_W = (DELAY_CYCLE > 1) ? $clog2(DELAY_CYCLE) : 1;

    word_t                 mem [2**ADDR_WIDTH];
    logic                  busy;
    logic [CNT_W-1:0]      cnt;
    word_t                 rdata_q;
    logic [ADDR_WIDTH-1:0] idx;
    logic                  accept;

    // memory comes up cleared.
    initial begin
        for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
            mem[i] = '0;
        end
    end

    assign idx       = req_addr[ADDR_WIDTH+1:2];   // upper bits alias.
    assign req_ready = !busy;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(DELAY_CYCLE - 1);
        end else if (busy) begin
            if (cnt == '0) begin
                busy <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            if (req_wen) begin
                mem[idx] <= req_wdata;
            end
            rdata_q <= req_wen ? '0 : mem[idx];
        end
    end

    assign resp_valid = busy && (cnt == '0);
    assign resp_rdata = rdata_q;

    a_resp_delay: assert property (@(posedge clk_in) disable iff (!rst_n)
        resp_valid |-> $past(accept, DELAY_CYCLE));

endmodule

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

    // one bus word, data or byte address.
    typedef logic [31:0] word_t;

    // cycle count, mtime and mtimecmp.
    typedef logic [63:0] time_t;

    // region nibble that selects the timer registers.
    localparam logic [3:0] mmio_base = 4'hf;

    // register selects, address bits 3..2.
    localparam logic [1:0] mmio_mtime_lo    = 2'd0;
    localparam logic [1:0] mmio_mtime_hi    = 2'd1;
    localparam logic [1:0] mmio_mtimecmp_lo = 2'd2;
    localparam logic [1:0] mmio_mtimecmp_hi = 2'd3;

    typedef struct packed {
        logic [3:0]  region;
        logic [25:0] index;   // word index.
        logic [1:0]  offset;
    } ram_addr_t;

    typedef struct packed {
        logic [3:0]  region;
        logic [23:0] unused;
        logic [1:0]  sel;     // timer register.
        logic [1:0]  offset;
    } mmio_addr_t;

    // same address word seen as RAM or as a timer register.
    typedef union packed {
        ram_addr_t  ram;
        mmio_addr_t mmio;
    } bus_addr_u;

endpackage

// ==== rtl/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int FMAX_MHZ    = 27,
    parameter int ADDR_WIDTH  = 10,
    parameter int DELAY_CYCLE = 4
) (
    input  logic           clk_in,
    input  logic           rst_n,
    input  logic           i_req_valid,
    output logic           i_req_ready,
    input  mem_pkg::word_t i_req_addr,
    output logic           i_resp_valid,
    output mem_pkg::word_t i_resp_rdata,
    input  logic           d_req_valid,
    output logic           d_req_ready,
    input  mem_pkg::word_t d_req_addr,
    input  logic           d_req_wen,
    input  mem_pkg::word_t d_req_wdata,
    output logic           d_resp_valid,
    output mem_pkg::word_t d_resp_rdata,
    output mem_pkg::time_t cycle,
    output mem_pkg::time_t mtime,
    output logic           timer_irq
);
    import mem_pkg::*;

    logic  m_req_valid, m_req_ready, m_req_wen, m_resp_valid;
    word_t m_req_addr, m_req_wdata, m_resp_rdata;

    logic  mem_req_valid, mem_req_ready, mem_req_wen, mem_resp_valid;
    word_t mem_req_addr, mem_req_wdata, mem_resp_rdata;

    time_t mtimecmp;

    mem_timer #(.FMAX_MHZ(FMAX_MHZ)) u_timer (
        .clk_in(clk_in), .rst_n(rst_n), .cycle(cycle), .mtime(mtime)
    );

    mmio_cntr u_mmio (
        .clk_in(clk_in), .rst_n(rst_n),
        .d_req_valid(d_req_valid), .d_req_ready(d_req_ready), .d_req_addr(d_req_addr),
        .d_req_wen(d_req_wen), .d_req_wdata(d_req_wdata),
        .d_resp_valid(d_resp_valid), .d_resp_rdata(d_resp_rdata),
        .m_req_valid(m_req_valid), .m_req_ready(m_req_ready), .m_req_addr(m_req_addr),
        .m_req_wen(m_req_wen), .m_req_wdata(m_req_wdata),
        .m_resp_valid(m_resp_valid), .m_resp_rdata(m_resp_rdata),
        .mtime(mtime), .mtimecmp(mtimecmp)
    );

    mem_bus_arbiter u_arb (
        .clk_in(clk_in), .rst_n(rst_n),
        .i_req_valid(i_req_valid), .i_req_ready(i_req_ready), .i_req_addr(i_req_addr),
        .i_resp_valid(i_resp_valid), .i_resp_rdata(i_resp_rdata),
        .d_req_valid(m_req_valid), .d_req_ready(m_req_ready), .d_req_addr(m_req_addr),
        .d_req_wen(m_req_wen), .d_req_wdata(m_req_wdata),
        .d_resp_valid(m_resp_valid), .d_resp_rdata(m_resp_rdata),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
        .mem_req_addr(mem_req_addr), .mem_req_wen(mem_req_wen),
        .mem_req_wdata(mem_req_wdata),
        .mem_resp_valid(mem_resp_valid), .mem_resp_rdata(mem_resp_rdata)
    );

    mem_model #(.ADDR_WIDTH(ADDR_WIDTH), .DELAY_CYCLE(DELAY_CYCLE)) u_mem (
        .clk_in(clk_in), .rst_n(rst_n),
        .req_valid(mem_req_valid), .req_ready(mem_req_ready), .req_addr(mem_req_addr),
        .req_wen(mem_req_wen), .req_wdata(mem_req_wdata),
        .resp_valid(mem_resp_valid), .resp_rdata(mem_resp_rdata)
    );

    assign timer_irq = (mtime >= mtimecmp);   // machine timer pending.

endmodule

// ==== rtl/mem_timer.sv ====
`timescale 1ns/1ps

module mem_timer #(
    parameter int FMAX_MHZ = 27
) (
    input  logic           clk_in,
    input  logic           rst_n,
    output mem_pkg::time_t cycle,
    output mem_pkg::time_t mtime
);

    // prescaler needs at least one bit even at 1 MHz.
    localparam int PRE_W = (FMAX_MHZ > 1) ? $clog2(FMAX_MHZ) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(FMAX_MHZ - 1);

    logic [PRE_W-1:0] presc;
    logic             tick_us;

    assign tick_us = (presc == PRE_LAST);

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

    // one mtime step per microsecond.
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            presc <= '0;
            mtime <= '0;
        end else if (tick_us) begin
            presc <= '0;
            mtime <= mtime + 64'd1;
        end else begin
            presc <= presc + 1'b1;
        end
    end

endmodule

// ==== rtl/mmio_cntr.sv ====
`timescale 1ns/1ps

module mmio_cntr (
    input  logic           clk_in,
    input  logic           rst_n,
    input  logic           d_req_valid,
    output logic           d_req_ready,
    input  mem_pkg::word_t d_req_addr,
    input  logic           d_req_wen,
    input  mem_pkg::word_t d_req_wdata,
    output logic           d_resp_valid,
    output mem_pkg::word_t d_resp_rdata,
    output logic           m_req_valid,
    input  logic           m_req_ready,
    output mem_pkg::word_t m_req_addr,
    output logic           m_req_wen,
    output mem_pkg::word_t m_req_wdata,
    input  logic           m_resp_valid,
    input  mem_pkg::word_t m_resp_rdata,
    input  mem_pkg::time_t mtime,
    output mem_pkg::time_t mtimecmp
);
    import mem_pkg::*;

    bus_addr_u addr_u;
    logic      is_mmio;
    logic      fwd_busy;      // forwarded access waiting for memory.
    logic      t_acc;
    logic      t_resp_valid;
    word_t     t_resp_rdata;
    word_t     t_rd;

    assign addr_u  = d_req_addr;
    assign is_mmio = (addr_u.mmio.region == mmio_base);
    assign t_acc   = d_req_valid && is_mmio && !fwd_busy;

    assign d_req_ready = is_mmio ? !fwd_busy : m_req_ready;

    // ram accesses go out word aligned.
    assign m_req_valid = d_req_valid && !is_mmio;
    assign m_req_addr  = {addr_u.ram.region, addr_u.ram.index, 2'b00};
    assign m_req_wen   = d_req_wen;
    assign m_req_wdata = d_req_wdata;

    always_comb begin
        case (addr_u.mmio.sel)
            mmio_mtime_lo:    t_rd = mtime[31:0];
            mmio_mtime_hi:    t_rd = mtime[63:32];
            mmio_mtimecmp_lo: t_rd = mtimecmp[31:0];
            default:          t_rd = mtimecmp[63:32];
        endcase
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            fwd_busy     <= 1'b0;
            t_resp_valid <= 1'b0;
            mtimecmp     <= '1;
        end else begin
            if (m_req_valid && m_req_ready) begin
                fwd_busy <= 1'b1;
            end else if (m_resp_valid) begin
                fwd_busy <= 1'b0;
            end
            t_resp_valid <= t_acc;
            if (t_acc && d_req_wen) begin
                // mtime itself is read only.
                if (addr_u.mmio.sel == mmio_mtimecmp_lo) begin
                    mtimecmp[31:0] <= d_req_wdata;
                end else if (addr_u.mmio.sel == mmio_mtimecmp_hi) begin
                    mtimecmp[63:32] <= d_req_wdata;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (t_acc) begin
            t_resp_rdata <= d_req_wen ? '0 : t_rd;   // writes answer zero.
        end
    end

    assign d_resp_valid = t_resp_valid || m_resp_valid;
    assign d_resp_rdata = t_resp_valid ? t_resp_rdata : m_resp_rdata;

    a_resp_has_access: assert property (@(posedge clk_in) disable iff (!rst_n)
        d_resp_valid |-> (fwd_busy || $past(t_acc)));

endmodule

// ==== src.f ====
rtl/mem_pkg.sv
rtl/mem_timer.sv
rtl/mmio_cntr.sv
rtl/mem_bus_arbiter.sv
rtl/mem_model.sv
rtl/mem_subsys_top.sv
verification/mem_subsys_tb.sv

// ==== verification/mem_subsys_stim.txt ====
# op port address data expected (hex). W write, R read, B data and fetch together
# (data holds the fetch address), T wait data cycles, C mtimecmp = mtime + data
W D 00000020 cafef00d 00000000
R D 00000020 00000000 cafef00d
W D 00001024 12345678 00000000
R D 00000024 00000000 12345678
W D 00001020 0badbeef 00000000
R D 00000020 00000000 0badbeef
W D 00000100 00000013 00000000
W D 00000104 00a00093 00000000
R I 00000100 00000000 00000013
R I 00000104 00000000 00a00093
W D 00000200 a5a5a5a5 00000000
B - 00000200 00000100 a5a5a5a5
B - 00000024 00000104 12345678
T - 00000000 0000010e 00000000
T - 00000000 0000021c 00000000
C - 00000000 00000003 00000000
R D 00000200 00000000 a5a5a5a5
C - 00000000 00000003 00000000

// ==== verification/mem_subsys_tb.sv ====
`timescale 1ns/1ps

module mem_subsys_tb;
    import mem_pkg::*;

    localparam int    FMAX_MHZ    = 27;
    localparam int    ADDR_WIDTH  = 10;
    localparam int    DELAY_CYCLE = 4;
    localparam int    LIMIT       = 200;
    localparam word_t MTIME_LO    = 32'hf000_0000;   // timer registers follow 4 bytes apart.

    logic  clk_in, rst_n, i_req_valid, i_req_ready, i_resp_valid;
    logic  d_req_valid, d_req_ready, d_req_wen, d_resp_valid, timer_irq;
    word_t i_req_addr, i_resp_rdata, d_req_addr, d_req_wdata, d_resp_rdata;
    time_t cycle, mtime;
    int    errors   = 0;
    int    timeouts = 0;
    word_t shadow [int];   // last word written per aliased index.

    mem_subsys_top #(
        .FMAX_MHZ(FMAX_MHZ), .ADDR_WIDTH(ADDR_WIDTH), .DELAY_CYCLE(DELAY_CYCLE)
    ) u_dut (.*);

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    function automatic int ram_index(word_t a);
        return int'(a[ADDR_WIDTH+1:2]);
    endfunction

    task automatic check_word(string name, word_t exp, word_t act);
        if (exp !== act) begin
            errors++;
            $display("mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_time(string name, time_t exp, time_t act, int tol);
        if (act + tol < exp || act > exp + tol) begin
            errors++;
            $display("mismatch %s: expected %h (+/- %0d) actual %h", name, exp, tol, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act) begin
            errors++;
            $display("mismatch %s: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic report_timeout(string what);
        timeouts++;
        $display("timeout: %s got no answer within %0d cycles", what, LIMIT);
    endtask

    // returns the latency in cycles from the acceptance edge.
    task automatic data_access(input word_t addr, input logic wen, input word_t wdata,
                               output word_t rdata, output int lat);
        int n;
        @(posedge clk_in);
        #1;
        d_req_valid = 1'b1;
        d_req_addr  = addr;
        d_req_wen   = wen;
        d_req_wdata = wdata;
        n = 0;
        lat = 0;
        do begin
            @(negedge clk_in);
            n++;
        end while (!d_req_ready && n < LIMIT);
        if (d_req_ready) begin
            @(posedge clk_in);
            #1;
            d_req_valid = 1'b0;
            while (lat < LIMIT) begin
                @(negedge clk_in);
                lat++;
                if (d_resp_valid) break;
            end
        end
        d_req_valid = 1'b0;
        rdata = d_resp_rdata;
        if (!d_resp_valid) report_timeout("data port request");
    endtask

    task automatic inst_read(input word_t addr, output word_t rdata, output realtime t);
        int n;
        @(posedge clk_in);
        #1;
        i_req_valid = 1'b1;
        i_req_addr  = addr;
        n = 0;
        do begin
            @(negedge clk_in);
            n++;
        end while (!i_req_ready && n < LIMIT);
        if (i_req_ready) begin
            @(posedge clk_in);
            #1;
            i_req_valid = 1'b0;
            n = 0;
            do begin
                @(negedge clk_in);
                n++;
            end while (!i_resp_valid && n < LIMIT);
        end
        i_req_valid = 1'b0;
        rdata = i_resp_rdata;
        t = $realtime;
        if (!i_resp_valid) report_timeout("instruction port request");
    endtask

    task automatic read_mtime(output time_t t);
        word_t lo, hi;
        int    lat;
        data_access(MTIME_LO, 1'b0, '0, lo, lat);
        data_access(MTIME_LO + 4, 1'b0, '0, hi, lat);
        t = {hi, lo};
    endtask

    initial begin
        int      fd, n, lat;
        string   line, name;
        byte     op, port;
        word_t   addr, data, exp, rd, ird;
        time_t   t0, t1, c0, m0;
        realtime t_d, t_i;
        void'($urandom(48));
        rst_n = 1'b0;
        i_req_valid = 1'b0;
        i_req_addr = '0;
        d_req_valid = 1'b0;
        d_req_addr = '0;
        d_req_wen = 1'b0;
        d_req_wdata = '0;
        repeat (8) @(posedge clk_in);
        #1 rst_n = 1'b1;
        fd = $fopen("verification/mem_subsys_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file");
        end
        while (fd != 0 && timeouts == 0 && $fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%c %c %h %h %h", op, port, addr, data, exp);
            name = $sformatf("%c%c @%h", op, port, addr);
            repeat ($urandom_range(3)) @(posedge clk_in);   // idle gap.
            case (op)
                "W": begin
                    data_access(addr, 1'b1, data, rd, lat);
                    check_word({name, " write response"}, '0, rd);
                    shadow[ram_index(addr)] = data;
                end
                "R": begin
                    if (port == "I") begin
                        inst_read(addr, rd, t_i);
                    end else begin
                        data_access(addr, 1'b0, '0, rd, lat);
                        check_word({name, " latency"}, DELAY_CYCLE, lat);
                    end
                    check_word({name, " read"}, exp, rd);
                end
                "B": begin
                    fork
                        begin
                            data_access(addr, 1'b0, '0, rd, lat);
                            t_d = $realtime;
                        end
                        inst_read(data, ird, t_i);
                    join
                    check_word({name, " data read"}, exp, rd);
                    check_word({name, " fetch"},
                               shadow.exists(ram_index(data)) ? shadow[ram_index(data)] : '0,
                               ird);
                    if (t_d >= t_i) begin
                        errors++;
                        $display("%s: the data response did not arrive first", name);
                    end
                end
                "T": begin
                    read_mtime(t0);
                    c0 = cycle;
                    m0 = mtime;
                    repeat (data) @(negedge clk_in);
                    check_time({name, " cycle growth"}, c0 + data, cycle, 0);
                    check_time({name, " mtime port growth"}, m0 + data / FMAX_MHZ, mtime, 1);
                    read_mtime(t1);
                    check_time({name, " mtime growth"}, t0 + data / FMAX_MHZ, t1, 1);
                end
                "C": begin
                    read_mtime(t0);
                    t1 = t0 + data;
                    data_access(MTIME_LO + 8, 1'b1, t1[31:0], rd, lat);
                    data_access(MTIME_LO + 12, 1'b1, t1[63:32], rd, lat);
                    check_flag({name, " irq after write"}, 1'b0, timer_irq);
                    n = 0;
                    while (!timer_irq && n < 3 * FMAX_MHZ + 2) begin
                        @(negedge clk_in);
                        n++;
                    end
                    if (!timer_irq) begin
                        errors++;
                        $display("%s: timer_irq did not rise in time", name);
                    end
                    data_access(MTIME_LO + 8, 1'b0, '0, rd, lat);
                    data_access(MTIME_LO + 12, 1'b0, '0, ird, lat);
                    check_time({name, " mtimecmp readback"}, t1, {ird, rd}, 0);
                end
                default: begin
                    errors++;
                    $display("unknown operation in stimulus line: %s", line);
                end
            endcase
        end
        if (fd != 0) $fclose(fd);
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
